//--- cache_bank/cache_bank.sv
`timescale 1ns/1ns

module cache_bank
(
    input  logic                                   clk_in,
    input  logic                                   rst_n,

    input  cache_packet_pkg::cache_packet_t        req_packets [cache_geom_pkg::NUM_PORT],
    output logic [cache_geom_pkg::NUM_PORT - 1 : 0] req_ack,

    input  cache_packet_pkg::cache_packet_t        fill_packet,
    output logic                                   fill_ack,

    output cache_packet_pkg::cache_packet_t        writeback_req,
    input  logic                                   writeback_ack,

    output cache_packet_pkg::cache_packet_t        miss_req,
    input  logic                                   miss_ack,

    output cache_packet_pkg::cache_packet_t        resp_packet,
    input  logic                                   resp_ack
);

typedef enum logic [2:0]
{
    STATE_IDLE,
    STATE_LOOKUP,
    STATE_WRITEBACK,
    STATE_MISS_REQ,
    STATE_FILL_WAIT,
    STATE_RESPOND
} state_t;

state_t state;

logic [cache_geom_pkg::NUM_SET_PER_BANK - 1 : 0] line_valid;
logic [cache_geom_pkg::NUM_SET_PER_BANK - 1 : 0] line_dirty;
cache_geom_pkg::tag_t  tag_arr  [cache_geom_pkg::NUM_SET_PER_BANK];
cache_geom_pkg::data_t data_arr [cache_geom_pkg::NUM_SET_PER_BANK];

cache_packet_pkg::cache_packet_t cur_req;
cache_geom_pkg::data_t           resp_data;
cache_geom_pkg::data_t           fill_word;

cache_geom_pkg::port_id_t   sel_port;
logic                       sel_valid;
cache_geom_pkg::set_index_t cur_set;
cache_geom_pkg::tag_t       cur_tag;
cache_geom_pkg::bank_id_t   cur_bank;
logic                       hit;

assign cur_set  = cur_req.addr[cache_geom_pkg::SET_LSB +: $bits(cache_geom_pkg::set_index_t)];
assign cur_tag  = cur_req.addr[cache_geom_pkg::TAG_LSB +: $bits(cache_geom_pkg::tag_t)];
assign cur_bank = cur_req.addr[cache_geom_pkg::BANK_LSB +: $bits(cache_geom_pkg::bank_id_t)];
assign hit      = line_valid[cur_set] && (tag_arr[cur_set] == cur_tag);

// write-allocate: a write miss installs the written word
assign fill_word = cur_req.is_write ? cur_req.data : fill_packet.data;

// lower port wins when both target this bank
always_comb
begin
    sel_valid = 1'b0;
    sel_port  = '0;
    for (int p = cache_geom_pkg::NUM_PORT - 1; p >= 0; p--)
    begin
        if (req_packets[p].valid)
        begin
            sel_valid = 1'b1;
            sel_port  = cache_geom_pkg::port_id_t'(p);
        end
    end
end

always_comb
begin
    req_ack           = '0;
    req_ack[sel_port] = (state == STATE_IDLE) && sel_valid;
end

assign fill_ack = (state == STATE_FILL_WAIT) && fill_packet.valid;

// victim address rebuilt from stored tag, same set and bank
always_comb
begin
    writeback_req          = '0;
    writeback_req.valid    = (state == STATE_WRITEBACK);
    writeback_req.is_write = cache_packet_pkg::MEM_CMD_WRITEBACK;
    writeback_req.port     = cur_req.port;
    writeback_req.addr     = {tag_arr[cur_set], cur_set, cur_bank,
                              {cache_geom_pkg::BANK_LSB{1'b0}}};
    writeback_req.data     = data_arr[cur_set];
end

always_comb
begin
    miss_req          = '0;
    miss_req.valid    = (state == STATE_MISS_REQ);
    miss_req.is_write = cache_packet_pkg::MEM_CMD_FILL;
    miss_req.port     = cur_req.port;
    miss_req.addr     = {cur_tag, cur_set, cur_bank, {cache_geom_pkg::BANK_LSB{1'b0}}};
end

always_comb
begin
    resp_packet          = cur_req;
    resp_packet.valid    = (state == STATE_RESPOND);
    resp_packet.data     = resp_data;
end

always_ff @(posedge clk_in or negedge rst_n)
begin
    if (!rst_n)
    begin
        state      <= STATE_IDLE;
        line_valid <= '0;
        line_dirty <= '0;
    end
    else
    begin
        case (state)
            STATE_IDLE:
            begin
                if (sel_valid)
                    state <= STATE_LOOKUP;
            end
            STATE_LOOKUP:
            begin
                if (hit)
                begin
                    if (cur_req.is_write)
                        line_dirty[cur_set] <= 1'b1;
                    state <= STATE_RESPOND;
                end
                else if (line_valid[cur_set] && line_dirty[cur_set])
                    state <= STATE_WRITEBACK;
                else
                    state <= STATE_MISS_REQ;
            end
            STATE_WRITEBACK:
            begin
                if (writeback_ack)
                    state <= STATE_MISS_REQ;
            end
            STATE_MISS_REQ:
            begin
                if (miss_ack)
                    state <= STATE_FILL_WAIT;
            end
            STATE_FILL_WAIT:
            begin
                if (fill_packet.valid)
                begin
                    line_valid[cur_set] <= 1'b1;
                    line_dirty[cur_set] <= cur_req.is_write;
                    state               <= STATE_RESPOND;
                end
            end
            STATE_RESPOND:
            begin
                if (resp_ack)
                    state <= STATE_IDLE;
            end
            default:
                state <= STATE_IDLE;
        endcase
    end
end

always_ff @(posedge clk_in)
begin
    case (state)
        STATE_IDLE:
        begin
            if (sel_valid)
                cur_req <= req_packets[sel_port];
        end
        STATE_LOOKUP:
        begin
            if (hit && cur_req.is_write)
            begin
                data_arr[cur_set] <= cur_req.data;
                resp_data         <= cur_req.data;
            end
            else if (hit)
                resp_data <= data_arr[cur_set];
        end
        STATE_FILL_WAIT:
        begin
            if (fill_packet.valid)
            begin
                tag_arr[cur_set]  <= cur_tag;
                data_arr[cur_set] <= fill_word;
                resp_data         <= fill_word;
            end
        end
        default:
        begin
        end
    endcase
end

endmodule

//--- common/cache_geom_pkg.sv
package cache_geom_pkg;

// cache geometry
localparam int NUM_PORT         = 2;
localparam int NUM_BANK         = 2;
localparam int NUM_SET_PER_BANK = 16;
localparam int QUEUE_DEPTH      = 4;

// address field positions
localparam int BANK_LSB = 2;
localparam int SET_LSB  = 3;
localparam int TAG_LSB  = 7;

typedef logic [31:0] addr_t;
typedef logic [31:0] data_t;

// tag is addr[31:7], set is addr[6:3], bank is addr[2]
typedef logic [31:TAG_LSB]                       tag_t;
typedef logic [$clog2(NUM_SET_PER_BANK) - 1 : 0] set_index_t;
typedef logic [$clog2(NUM_BANK) - 1 : 0]         bank_id_t;

typedef logic [$clog2(NUM_PORT) - 1 : 0]         port_id_t;

endpackage

//--- common/cache_packet_pkg.sv
package cache_packet_pkg;

// one packet format for requests, responses, memory commands and fills
typedef struct packed
{
    logic                     valid;
    logic                     is_write;
    cache_geom_pkg::port_id_t port;
    cache_geom_pkg::addr_t    addr;
    cache_geom_pkg::data_t    data;
} cache_packet_t;

// memory side meaning of is_write
localparam logic MEM_CMD_FILL      = 1'b0;
localparam logic MEM_CMD_WRITEBACK = 1'b1;

endpackage

//--- logic/fifo_queue.sv
`timescale 1ns/1ns

module fifo_queue
(
    input  logic                            clk_in,
    input  logic                            rst_n,

    input  cache_packet_pkg::cache_packet_t push_packet,
    output logic                            push_ack,

    output cache_packet_pkg::cache_packet_t head_packet,
    input  logic                            pop_ack
);

typedef logic [$clog2(cache_geom_pkg::QUEUE_DEPTH) - 1 : 0]     ptr_t;
typedef logic [$clog2(cache_geom_pkg::QUEUE_DEPTH + 1) - 1 : 0] count_t;

cache_packet_pkg::cache_packet_t entries [cache_geom_pkg::QUEUE_DEPTH];

ptr_t   wr_ptr;
ptr_t   rd_ptr;
count_t count;
logic   do_push;
logic   do_pop;

assign push_ack = push_packet.valid && (count != count_t'(cache_geom_pkg::QUEUE_DEPTH));
assign do_push  = push_ack;
assign do_pop   = pop_ack && (count != '0);

always_comb
begin
    head_packet       = entries[rd_ptr];
    head_packet.valid = (count != '0);
end

// depth is a power of two, pointers wrap by themselves
always_ff @(posedge clk_in or negedge rst_n)
begin
    if (!rst_n)
    begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end
    else
    begin
        if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
        if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
        case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

always_ff @(posedge clk_in)
begin
    if (do_push)
        entries[wr_ptr] <= push_packet;
end

endmodule

//--- logic/priority_arbiter.sv
`timescale 1ns/1ns

module priority_arbiter
#(
    parameter int NUM_REQUEST = 2
)
(
    input  cache_packet_pkg::cache_packet_t req_packets [NUM_REQUEST],
    output logic [NUM_REQUEST - 1 : 0]      req_ack,

    output cache_packet_pkg::cache_packet_t grant_packet,
    input  logic                            grant_ack
);

typedef logic [$clog2(NUM_REQUEST) - 1 : 0] idx_t;

idx_t grant_idx;
logic grant_valid;

// lowest index wins, so scan from the top down
always_comb
begin
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int i = NUM_REQUEST - 1; i >= 0; i--)
    begin
        if (req_packets[i].valid)
        begin
            grant_valid = 1'b1;
            grant_idx   = idx_t'(i);
        end
    end
end

always_comb
begin
    if (grant_valid)
        grant_packet = req_packets[grant_idx];
    else
        grant_packet = '0;
end

// ack goes back only to the winner
always_comb
begin
    req_ack            = '0;
    req_ack[grant_idx] = grant_valid && grant_ack;
end

endmodule

//--- logic/unified_cache.sv
`timescale 1ns/1ns

module unified_cache
(
    input  logic                                   clk_in,
    input  logic                                   rst_n,

    input  cache_packet_pkg::cache_packet_t        in_packet [cache_geom_pkg::NUM_PORT],
    output logic [cache_geom_pkg::NUM_PORT - 1 : 0] in_ack,

    output cache_packet_pkg::cache_packet_t        out_packet [cache_geom_pkg::NUM_PORT],
    input  logic [cache_geom_pkg::NUM_PORT - 1 : 0] out_ack,

    input  cache_packet_pkg::cache_packet_t        from_mem_packet,
    output logic                                   from_mem_ack,

    output cache_packet_pkg::cache_packet_t        to_mem_packet,
    input  logic                                   to_mem_ack
);

cache_packet_pkg::cache_packet_t queue_head [cache_geom_pkg::NUM_PORT];
logic [cache_geom_pkg::NUM_PORT - 1 : 0] queue_pop;

cache_packet_pkg::cache_packet_t bank_req [cache_geom_pkg::NUM_BANK][cache_geom_pkg::NUM_PORT];
logic [cache_geom_pkg::NUM_PORT - 1 : 0] bank_issue_ack [cache_geom_pkg::NUM_BANK];

cache_packet_pkg::cache_packet_t bank_fill [cache_geom_pkg::NUM_BANK];
logic [cache_geom_pkg::NUM_BANK - 1 : 0] bank_fill_ack;

// writebacks in the low slots, misses above them
cache_packet_pkg::cache_packet_t mem_req [2 * cache_geom_pkg::NUM_BANK];
logic [2 * cache_geom_pkg::NUM_BANK - 1 : 0] mem_req_ack;

cache_packet_pkg::cache_packet_t bank_resp [cache_geom_pkg::NUM_BANK];
logic [cache_geom_pkg::NUM_BANK - 1 : 0] bank_resp_ack;

cache_packet_pkg::cache_packet_t port_resp [cache_geom_pkg::NUM_PORT][cache_geom_pkg::NUM_BANK];
logic [cache_geom_pkg::NUM_BANK - 1 : 0] port_resp_ack [cache_geom_pkg::NUM_PORT];

for (genvar p = 0; p < cache_geom_pkg::NUM_PORT; p++)
begin : g_queue
    fifo_queue u_queue
    (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .push_packet (in_packet[p]),
        .push_ack    (in_ack[p]),
        .head_packet (queue_head[p]),
        .pop_ack     (queue_pop[p])
    );
end

// steer queue heads and fills to the bank named by the address
always_comb
begin
    for (int b = 0; b < cache_geom_pkg::NUM_BANK; b++)
    begin
        for (int p = 0; p < cache_geom_pkg::NUM_PORT; p++)
        begin
            bank_req[b][p]       = queue_head[p];
            bank_req[b][p].valid = queue_head[p].valid &&
                (queue_head[p].addr[cache_geom_pkg::BANK_LSB +: $bits(cache_geom_pkg::bank_id_t)]
                 == cache_geom_pkg::bank_id_t'(b));
        end
        bank_fill[b]       = from_mem_packet;
        bank_fill[b].valid = from_mem_packet.valid &&
            (from_mem_packet.addr[cache_geom_pkg::BANK_LSB +: $bits(cache_geom_pkg::bank_id_t)]
             == cache_geom_pkg::bank_id_t'(b));
    end
end

// acks back toward queues and memory
always_comb
begin
    queue_pop = '0;
    for (int b = 0; b < cache_geom_pkg::NUM_BANK; b++)
        queue_pop = queue_pop | bank_issue_ack[b];
end

assign from_mem_ack = |bank_fill_ack;

for (genvar b = 0; b < cache_geom_pkg::NUM_BANK; b++)
begin : g_bank
    cache_bank u_bank
    (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .req_packets   (bank_req[b]),
        .req_ack       (bank_issue_ack[b]),
        .fill_packet   (bank_fill[b]),
        .fill_ack      (bank_fill_ack[b]),
        .writeback_req (mem_req[b]),
        .writeback_ack (mem_req_ack[b]),
        .miss_req      (mem_req[cache_geom_pkg::NUM_BANK + b]),
        .miss_ack      (mem_req_ack[cache_geom_pkg::NUM_BANK + b]),
        .resp_packet   (bank_resp[b]),
        .resp_ack      (bank_resp_ack[b])
    );
end

priority_arbiter
#(
    .NUM_REQUEST (2 * cache_geom_pkg::NUM_BANK)
)
u_to_mem_arbiter
(
    .req_packets  (mem_req),
    .req_ack      (mem_req_ack),
    .grant_packet (to_mem_packet),
    .grant_ack    (to_mem_ack)
);

// each port only sees responses tagged with its own id
always_comb
begin
    bank_resp_ack = '0;
    for (int p = 0; p < cache_geom_pkg::NUM_PORT; p++)
    begin
        for (int b = 0; b < cache_geom_pkg::NUM_BANK; b++)
        begin
            port_resp[p][b]       = bank_resp[b];
            port_resp[p][b].valid = bank_resp[b].valid &&
                (bank_resp[b].port == cache_geom_pkg::port_id_t'(p));
        end
        bank_resp_ack = bank_resp_ack | port_resp_ack[p];
    end
end

for (genvar p = 0; p < cache_geom_pkg::NUM_PORT; p++)
begin : g_resp
    priority_arbiter
    #(
        .NUM_REQUEST (cache_geom_pkg::NUM_BANK)
    )
    u_resp_arbiter
    (
        .req_packets  (port_resp[p]),
        .req_ack      (port_resp_ack[p]),
        .grant_packet (out_packet[p]),
        .grant_ack    (out_ack[p])
    );
end

endmodule

//--- run.sh
#!/bin/sh
# compile and run the unified cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ns -f vlog.f \
    --top-module tb_unified_cache -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0

//--- tb/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model
#(
    parameter logic [31:0] FILL_OFFSET = 32'h1000_0000
)
(
    input  logic                            clk_in,
    input  cache_packet_pkg::cache_packet_t cmd_packet,
    output logic                            cmd_ack,
    output cache_packet_pkg::cache_packet_t fill_packet,
    input  logic                            fill_ack
);

cache_geom_pkg::data_t store [cache_geom_pkg::addr_t];
cache_geom_pkg::addr_t fill_addr_q [$];
int                    fill_delay_q [$];
cache_geom_pkg::addr_t fill_addr;
logic [7:0]            lfsr_state;
int                    ack_wait;
int                    delay;
logic                  cmd_seen;
logic                  cmd_done;
logic                  fill_done;

// galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
task automatic take_bits(input int n, output int value);
    logic out_bit;
    value = 0;
    for (int i = 0; i < n; i++)
    begin
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit)
            lfsr_state = lfsr_state ^ 8'hB8;
        value = (value << 1) | int'(out_bit);
    end
endtask

initial
begin
    cmd_ack     = 1'b0;
    fill_packet = '0;
    lfsr_state  = 8'd8;
    ack_wait    = -1;
    forever
    begin
        // settled values here, the transfer itself happens at the next edge
        @(negedge clk_in);
        cmd_seen  = cmd_packet.valid;
        cmd_done  = cmd_ack && cmd_packet.valid;
        fill_done = fill_packet.valid && fill_ack;
        if (cmd_done && cmd_packet.is_write == cache_packet_pkg::MEM_CMD_WRITEBACK)
            store[cmd_packet.addr] = cmd_packet.data;
        else if (cmd_done)
        begin
            take_bits(2, delay);
            fill_addr_q.push_back(cmd_packet.addr);
            fill_delay_q.push_back(delay);
        end
        @(posedge clk_in);
        #10;
        // ack is a one-cycle pulse
        if (cmd_ack)
            cmd_ack = 1'b0;
        else if (cmd_seen)
        begin
            if (ack_wait < 0)
                take_bits(2, ack_wait);
            cmd_ack  = (ack_wait == 0);
            ack_wait = ack_wait - 1;
        end
        if (fill_done)
            fill_packet = '0;
        else if (!fill_packet.valid && fill_addr_q.size() > 0)
        begin
            if (fill_delay_q[0] > 0)
                fill_delay_q[0] = fill_delay_q[0] - 1;
            else
            begin
                void'(fill_delay_q.pop_front());
                fill_addr            = fill_addr_q.pop_front();
                fill_packet.valid    = 1'b1;
                fill_packet.is_write = cache_packet_pkg::MEM_CMD_FILL;
                fill_packet.addr     = fill_addr;
                // untouched words read as address plus offset
                fill_packet.data     = store.exists(fill_addr) ? store[fill_addr]
                                                               : fill_addr + FILL_OFFSET;
            end
        end
    end
end

endmodule

//--- tb/tb_unified_cache.sv
`timescale 1ns/1ns

module tb_unified_cache;

localparam logic [31:0] FILL_OFFSET = 32'h1000_0000;
localparam int          WAIT_LIMIT  = 300;

typedef struct packed
{
    cache_geom_pkg::port_id_t port;
    logic                     is_write;
    cache_geom_pkg::addr_t    addr;
    cache_geom_pkg::data_t    data;
    logic [3:0]               stall;
    logic                     chain;
} step_t;

logic clk_in;
logic rst_n;

cache_packet_pkg::cache_packet_t         in_packet [cache_geom_pkg::NUM_PORT];
logic [cache_geom_pkg::NUM_PORT - 1 : 0] in_ack;
cache_packet_pkg::cache_packet_t         out_packet [cache_geom_pkg::NUM_PORT];
logic [cache_geom_pkg::NUM_PORT - 1 : 0] out_ack;
cache_packet_pkg::cache_packet_t         from_mem_packet;
logic                                    from_mem_ack;
cache_packet_pkg::cache_packet_t         to_mem_packet;
logic                                    to_mem_ack;

step_t                           steps [$];
int                              issue_q [cache_geom_pkg::NUM_PORT][$];
cache_packet_pkg::cache_packet_t exp_resp [cache_geom_pkg::NUM_PORT][$];
int                              exp_stall [cache_geom_pkg::NUM_PORT][$];
int                              stall_left [cache_geom_pkg::NUM_PORT];
cache_packet_pkg::cache_packet_t exp_wb [$];
cache_packet_pkg::cache_packet_t seen_wb [$];

// shadow of memory contents and of each line's state
cache_geom_pkg::data_t shadow [cache_geom_pkg::addr_t];
logic                  line_valid [cache_geom_pkg::NUM_BANK][cache_geom_pkg::NUM_SET_PER_BANK];
logic                  line_dirty [cache_geom_pkg::NUM_BANK][cache_geom_pkg::NUM_SET_PER_BANK];
cache_geom_pkg::tag_t  line_tag   [cache_geom_pkg::NUM_BANK][cache_geom_pkg::NUM_SET_PER_BANK];

int   error_count;
int   check_count;
int   first_step;
logic timed_out;

unified_cache i_dut
(
    .clk_in          (clk_in),
    .rst_n           (rst_n),
    .in_packet       (in_packet),
    .in_ack          (in_ack),
    .out_packet      (out_packet),
    .out_ack         (out_ack),
    .from_mem_packet (from_mem_packet),
    .from_mem_ack    (from_mem_ack),
    .to_mem_packet   (to_mem_packet),
    .to_mem_ack      (to_mem_ack)
);

tb_mem_model
#(
    .FILL_OFFSET (FILL_OFFSET)
)
u_mem
(
    .clk_in      (clk_in),
    .cmd_packet  (to_mem_packet),
    .cmd_ack     (to_mem_ack),
    .fill_packet (from_mem_packet),
    .fill_ack    (from_mem_ack)
);

always
begin
    #50 clk_in = ~clk_in;
end

task automatic load_steps();
    // port, write, addr, data, out_ack stall, chained with next
    steps.push_back(step_t'({1'b0, 1'b0, 32'h0000_0040, 32'h0000_0000, 4'd0, 1'b0}));
    steps.push_back(step_t'({1'b1, 1'b1, 32'h0000_0104, 32'hCAFE_0001, 4'd0, 1'b0}));
    steps.push_back(step_t'({1'b1, 1'b0, 32'h0000_0104, 32'h0000_0000, 4'd0, 1'b0}));
    steps.push_back(step_t'({1'b0, 1'b1, 32'h0000_0208, 32'h1234_5678, 4'd0, 1'b0}));
    steps.push_back(step_t'({1'b0, 1'b0, 32'h0000_0208, 32'h0000_0000, 4'd0, 1'b0}));
    // same bank and set as 0x208, evicts the dirty line
    steps.push_back(step_t'({1'b0, 1'b0, 32'h0000_0288, 32'h0000_0000, 4'd0, 1'b0}));
    steps.push_back(step_t'({1'b0, 1'b0, 32'h0000_0208, 32'h0000_0000, 4'd0, 1'b0}));
    steps.push_back(step_t'({1'b0, 1'b0, 32'h0000_0300, 32'h0000_0000, 4'd0, 1'b1}));
    steps.push_back(step_t'({1'b1, 1'b0, 32'h0000_0014, 32'h0000_0000, 4'd0, 1'b0}));
    steps.push_back(step_t'({1'b1, 1'b1, 32'h0000_0040, 32'hA5A5_0040, 4'd0, 1'b1}));
    steps.push_back(step_t'({1'b0, 1'b1, 32'h0000_0184, 32'h5A5A_0184, 4'd0, 1'b0}));
    // queued behind a stalled response on the same bank
    steps.push_back(step_t'({1'b0, 1'b0, 32'h0000_0208, 32'h0000_0000, 4'd6, 1'b1}));
    steps.push_back(step_t'({1'b0, 1'b1, 32'h0000_0288, 32'h0BAD_F00D, 4'd0, 1'b1}));
    steps.push_back(step_t'({1'b0, 1'b0, 32'h0000_0208, 32'h0000_0000, 4'd0, 1'b0}));
    steps.push_back(step_t'({1'b1, 1'b0, 32'h0000_0184, 32'h0000_0000, 4'd3, 1'b0}));
    steps.push_back(step_t'({1'b0, 1'b0, 32'h0000_0104, 32'h0000_0000, 4'd0, 1'b0}));
endtask

function automatic cache_geom_pkg::data_t memory_word(input cache_geom_pkg::addr_t a);
    return shadow.exists(a) ? shadow[a] : a + FILL_OFFSET;
endfunction

task automatic report_mismatch(input string name, input logic [31:0] want,
                               input logic [31:0] got);
    $display("mismatch %s expected %h got %h", name, want, got);
    error_count++;
endtask

// direct mapped, write-back, write-allocate
task automatic predict(input step_t s);
    cache_packet_pkg::cache_packet_t resp;
    cache_packet_pkg::cache_packet_t victim;
    cache_geom_pkg::tag_t            tag;
    int                              bank;
    int                              set;
    bank = int'(s.addr[2]);
    set  = int'(s.addr[6:3]);
    tag  = s.addr[31:7];
    if (!(line_valid[bank][set] && line_tag[bank][set] == tag))
    begin
        if (line_valid[bank][set] && line_dirty[bank][set])
        begin
            victim      = '0;
            victim.addr = {line_tag[bank][set], s.addr[6:2], 2'b00};
            victim.data = memory_word(victim.addr);
            exp_wb.push_back(victim);
        end
        line_valid[bank][set] = 1'b1;
        line_tag[bank][set]   = tag;
        line_dirty[bank][set] = 1'b0;
    end
    if (s.is_write)
    begin
        shadow[s.addr]        = s.data;
        line_dirty[bank][set] = 1'b1;
    end
    resp          = '0;
    resp.valid    = 1'b1;
    resp.is_write = s.is_write;
    resp.port     = s.port;
    resp.addr     = s.addr;
    resp.data     = memory_word(s.addr);
    exp_resp[s.port].push_back(resp);
    exp_stall[s.port].push_back(int'(s.stall));
endtask

task automatic check_resp(input int p);
    cache_packet_pkg::cache_packet_t want;
    check_count++;
    if (exp_resp[p].size() == 0)
    begin
        $display("port %0d gave a response that was never requested", p);
        error_count++;
    end
    else
    begin
        want = exp_resp[p][0];
        if (out_packet[p].addr !== want.addr)
            report_mismatch($sformatf("out_packet[%0d].addr", p), want.addr, out_packet[p].addr);
        if (out_packet[p].data !== want.data)
            report_mismatch($sformatf("out_packet[%0d].data", p), want.data, out_packet[p].data);
        if (out_packet[p].port !== want.port)
            report_mismatch($sformatf("out_packet[%0d].port", p), 32'(want.port),
                            32'(out_packet[p].port));
        if (out_packet[p].is_write !== want.is_write)
            report_mismatch($sformatf("out_packet[%0d].is_write", p), 32'(want.is_write),
                            32'(out_packet[p].is_write));
    end
endtask

task automatic check_writebacks();
    logic found;
    check_count++;
    if (seen_wb.size() != exp_wb.size())
        report_mismatch("to_mem_packet writebacks", exp_wb.size(), seen_wb.size());
    foreach (exp_wb[i])
    begin
        found = 1'b0;
        foreach (seen_wb[j])
            if (seen_wb[j].addr == exp_wb[i].addr && seen_wb[j].data == exp_wb[i].data)
                found = 1'b1;
        if (!found)
        begin
            $display("writeback of address %h with data %h never reached memory",
                     exp_wb[i].addr, exp_wb[i].data);
            error_count++;
        end
    end
    exp_wb.delete();
    seen_wb.delete();
endtask

// issue a group of steps and collect every response
task automatic run_group(input int first, input int last, output logic timeout);
    logic  seen_valid [cache_geom_pkg::NUM_PORT];
    step_t s;
    int    cycles;
    logic  busy;
    for (int i = first; i <= last; i++)
        issue_q[steps[i].port].push_back(i);
    cycles = 0;
    busy   = 1'b1;
    while (busy && cycles < WAIT_LIMIT)
    begin
        @(negedge clk_in);
        cycles++;
        for (int p = 0; p < cache_geom_pkg::NUM_PORT; p++)
        begin
            seen_valid[p] = out_packet[p].valid;
            if (in_packet[p].valid && in_ack[p])
                predict(steps[issue_q[p].pop_front()]);
            if (out_packet[p].valid)
                check_resp(p);
            if (out_packet[p].valid && out_ack[p] && exp_resp[p].size() > 0)
            begin
                void'(exp_resp[p].pop_front());
                void'(exp_stall[p].pop_front());
            end
        end
        if (to_mem_packet.valid && to_mem_ack && to_mem_packet.is_write)
            seen_wb.push_back(to_mem_packet);
        @(posedge clk_in);
        #10;
        busy = 1'b0;
        for (int p = 0; p < cache_geom_pkg::NUM_PORT; p++)
        begin
            in_packet[p] = '0;
            if (issue_q[p].size() > 0)
            begin
                s                     = steps[issue_q[p][0]];
                in_packet[p].valid    = 1'b1;
                in_packet[p].is_write = s.is_write;
                in_packet[p].port     = s.port;
                in_packet[p].addr     = s.addr;
                in_packet[p].data     = s.data;
            end
            // hold off the ack for the step's stall count
            if (out_ack[p])
                out_ack[p] = 1'b0;
            else if (seen_valid[p] && exp_stall[p].size() > 0)
            begin
                if (stall_left[p] < 0)
                    stall_left[p] = exp_stall[p][0];
                out_ack[p]    = (stall_left[p] == 0);
                stall_left[p] = stall_left[p] - 1;
            end
            if (issue_q[p].size() > 0 || exp_resp[p].size() > 0)
                busy = 1'b1;
        end
    end
    timeout = busy;
endtask

initial
begin
    clk_in      = 1'b0;
    rst_n       = 1'b0;
    in_packet   = '{default: '0};
    out_ack     = '0;
    error_count = 0;
    check_count = 0;
    stall_left  = '{default: -1};
    line_valid  = '{default: '0};
    line_dirty  = '{default: '0};
    load_steps();
    repeat (5) @(posedge clk_in);
    #10;
    rst_n = 1'b1;

    // quiet outputs out of reset
    @(negedge clk_in);
    check_count++;
    for (int p = 0; p < cache_geom_pkg::NUM_PORT; p++)
    begin
        if (out_packet[p].valid !== 1'b0)
            report_mismatch($sformatf("out_packet[%0d].valid", p), 0, 32'(out_packet[p].valid));
        if (in_ack[p] !== 1'b0)
            report_mismatch($sformatf("in_ack[%0d]", p), 0, 32'(in_ack[p]));
    end
    if (to_mem_packet.valid !== 1'b0)
        report_mismatch("to_mem_packet.valid", 0, 32'(to_mem_packet.valid));

    first_step = 0;
    timed_out  = 1'b0;
    for (int i = 0; i < steps.size() && !timed_out; i++)
    begin
        if (!steps[i].chain)
        begin
            run_group(first_step, i, timed_out);
            if (!timed_out)
                check_writebacks();
            first_step = i + 1;
        end
    end
    if (timed_out)
    begin
        $display("requests were not accepted and answered within %0d cycles", WAIT_LIMIT);
        error_count++;
    end

    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0)
        $display("TEST PASS");
    else
        $display("TEST FAIL");
    $finish;
end

endmodule

//--- vlog.f
common/cache_geom_pkg.sv
common/cache_packet_pkg.sv
logic/fifo_queue.sv
logic/priority_arbiter.sv
cache_bank/cache_bank.sv
logic/unified_cache.sv
tb/tb_mem_model.sv
tb/tb_unified_cache.sv
